//--- hw/loader_pkg.sv
// Shared iNES constants, mapper-flag bit positions and loader phase type
// Imported by the loader RTL and the testbench
package loader_pkg;

  // iNES header layout
  localparam int INES_HDR_LEN = 16;                // Header bytes before PRG data
  localparam logic [7:0] INES_MAGIC0 = 8'h4E;      // 'N'
  localparam logic [7:0] INES_MAGIC1 = 8'h45;      // 'E'
  localparam logic [7:0] INES_MAGIC2 = 8'h53;      // 'S'
  localparam logic [7:0] INES_MAGIC3 = 8'h1A;      // EOF marker

  // Page sizes as shift amounts
  localparam int PRG_PAGE_SHIFT = 14;              // 16 KiB PRG pages
  localparam int CHR_PAGE_SHIFT = 13;              // 8 KiB CHR pages

  // Mapper flags word handed to the console
  localparam int FLAGS_WIDTH = 32;
  localparam int FLAG_MAPPER_LO = 0;               // 8-bit mapper number
  localparam int FLAG_PRG_SIZE = 8;                // 3-bit size code
  localparam int FLAG_CHR_SIZE = 11;               // 3-bit size code
  localparam int FLAG_MIRROR = 14;
  localparam int FLAG_CHR_RAM = 15;                // No CHR ROM in image
  localparam int FLAG_FOUR_SCREEN = 16;
  // Bits above FLAG_FOUR_SCREEN stay zero

  // Loader phase
  typedef enum logic [2:0] {
    HEADER   = 3'd0,   // Collecting header bytes
    PRG      = 3'd1,   // Program ROM bytes
    CHR      = 3'd2,   // Character ROM bytes
    FINISHED = 3'd3,   // All data written
    FAILED   = 3'd4    // Bad signature or trainer present
  } loader_state_t;

endpackage

//--- hw/ines_loader.sv
// iNES header parser and write address sequencer
// Turns the download byte stream into PRG/CHR memory writes plus mapper flags
`timescale 1ns/1ns

module ines_loader
  import loader_pkg::*;
#(
  parameter int ADDR_WIDTH = 22
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [7:0]             byte_data,
  input  logic                   byte_strobe,
  input  logic                   invert_mirroring,
  output logic [ADDR_WIDTH-1:0]  wr_addr,
  output logic [7:0]             wr_data,
  output logic                   wr_strobe,
  output logic [FLAGS_WIDTH-1:0] flags,
  output logic                   done,
  output logic                   error
);

  // Byte counter wide enough for 255 PRG pages
  localparam int CNT_W = 8 + PRG_PAGE_SHIFT;
  localparam int HDR_W = $clog2(INES_HDR_LEN);
  localparam logic [ADDR_WIDTH-1:0] CHR_BASE = {1'b1, {(ADDR_WIDTH-1){1'b0}}};  // Top addr bit

  loader_state_t         state;
  logic [HDR_W-1:0]      hdr_idx;
  logic [7:0]            ines [INES_HDR_LEN];   // Raw header bytes
  logic [CNT_W-1:0]      bytes_left;
  logic [ADDR_WIDTH-1:0] addr;

  logic [7:0] prg_pages;
  logic [7:0] chr_pages;
  logic       sig_ok;
  logic       is_nes20;
  logic       upper_nonzero;
  logic       is_dirty;
  logic [7:0] mapper;

  // Ceil-log2 of page count, saturating at 7
  function automatic logic [2:0] size_code(input logic [7:0] pages);
    logic [2:0] code;
    int i;
    code = 3'd0;
    for (i = 0; i < 7; i++) begin
      if (pages > (8'd1 << i))
        code = 3'(i + 1);
    end
    return code;
  endfunction

  assign prg_pages = ines[4];
  assign chr_pages = ines[5];   // Zero means CHR RAM
  assign sig_ok = (ines[0] == INES_MAGIC0) && (ines[1] == INES_MAGIC1) &&
                  (ines[2] == INES_MAGIC2) && (ines[3] == INES_MAGIC3);
  assign is_nes20 = (ines[7][3:2] == 2'b10);

  // Old dumps often carry junk in bytes 8-15
  always_comb begin
    upper_nonzero = 1'b0;
    for (int i = 8; i < INES_HDR_LEN; i++) begin
      upper_nonzero = upper_nonzero | (ines[i] != 8'd0);
    end
  end

  assign is_dirty = !is_nes20 && upper_nonzero;
  assign mapper = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};  // Drop hi nibble if dirty

  always_comb begin
    flags = '0;
    flags[FLAG_MAPPER_LO +: 8] = mapper;
    flags[FLAG_PRG_SIZE +: 3] = size_code(prg_pages);
    flags[FLAG_CHR_SIZE +: 3] = size_code(chr_pages);
    flags[FLAG_MIRROR] = ines[6][0] ^ invert_mirroring;
    flags[FLAG_CHR_RAM] = (chr_pages == 8'd0);
    flags[FLAG_FOUR_SCREEN] = ines[6][3];
  end

  // Write goes out in the strobe cycle itself
  assign wr_strobe = byte_strobe && (bytes_left != '0) && (state == PRG || state == CHR);
  assign wr_addr = addr;
  assign wr_data = byte_data;

  // Header store, no reset needed
  always_ff @(posedge clk) begin
    if (state == HEADER && byte_strobe)
      ines[hdr_idx] <= byte_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= HEADER;
      hdr_idx <= '0;
      bytes_left <= '0;
      addr <= '0;        // PRG starts at zero
      done <= 1'b0;
      error <= 1'b0;
    end else begin
      case (state)
        HEADER: begin
          if (byte_strobe) begin
            hdr_idx <= hdr_idx + 1'b1;
            if (hdr_idx == HDR_W'(INES_HDR_LEN - 1)) begin
              bytes_left <= CNT_W'({prg_pages, {PRG_PAGE_SHIFT{1'b0}}});
              // Trainers are not supported
              state <= (sig_ok && !ines[6][2]) ? PRG : FAILED;
            end
          end
        end
        PRG, CHR: begin
          if (bytes_left != '0) begin
            if (byte_strobe) begin
              bytes_left <= bytes_left - 1'b1;
              addr <= addr + 1'b1;
            end
          end else if (state == PRG) begin
            state <= CHR;   // Idle cycle between phases
            addr <= CHR_BASE;
            bytes_left <= CNT_W'({chr_pages, {CHR_PAGE_SHIFT{1'b0}}});
          end else begin
            state <= FINISHED;
            done <= 1'b1;
          end
        end
        FINISHED: ;   // Late strobes ignored
        FAILED: begin
          done <= 1'b1;
          error <= 1'b1;
        end
        default: state <= FAILED;
      endcase
    end
  end

endmodule

//--- hw/write_slot_sync.sv
// Moves each loader write onto the console memory-slot cycle
// Holds one pending write until the slot counter reaches CE_DIV-1
`timescale 1ns/1ns

module write_slot_sync #(
  parameter int ADDR_WIDTH = 22,
  parameter int CE_DIV = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [7:0]            wr_data,
  input  logic                  wr_strobe,
  output logic [ADDR_WIDTH-1:0] mem_addr,
  output logic [7:0]            mem_data,
  output logic                  mem_write
);

  localparam int SLOT_W = (CE_DIV > 1) ? $clog2(CE_DIV) : 1;

  logic [SLOT_W-1:0] slot;
  logic              slot_last;
  logic              pending;

  assign slot_last = (slot == SLOT_W'(CE_DIV - 1));

  // Free-running slot counter
  always_ff @(posedge clk) begin
    if (reset)
      slot <= '0;
    else if (slot_last)
      slot <= '0;
    else
      slot <= slot + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset)
      pending <= 1'b0;
    else if (wr_strobe)
      pending <= 1'b1;   // New write wins over issue in same cycle
    else if (slot_last)
      pending <= 1'b0;
  end

  // Write payload, no reset
  always_ff @(posedge clk) begin
    if (wr_strobe) begin
      mem_addr <= wr_addr;
      mem_data <= wr_data;
    end
  end

  assign mem_write = pending && slot_last;   // One cycle per write

endmodule

//--- hw/load_control.sv
// Download reset hold, loader reset, load status latching and status LED
// Sits between the host download signal and the console reset
`timescale 1ns/1ns

module load_control
  import loader_pkg::*;
#(
  parameter int RESET_HOLD = 255,
  parameter int BLINK_BITS = 24
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   downloading,
  input  logic                   done,
  input  logic                   error,
  input  logic [FLAGS_WIDTH-1:0] flags,
  output logic                   loader_reset,
  output logic [FLAGS_WIDTH-1:0] mapper_flags,
  output logic                   loaded,
  output logic                   failed,
  output logic                   system_reset,
  output logic                   led
);

  localparam int HOLD_W = $clog2(RESET_HOLD + 1);

  logic [HOLD_W-1:0]     hold_cnt;
  logic                  init_wait;   // Before first download
  logic                  dl_q;
  logic                  dl_rise;
  logic [BLINK_BITS-1:0] blink;

  assign dl_rise = downloading && !dl_q;

  // Hold counter reloads during download, drains after
  always_ff @(posedge clk) begin
    if (reset)
      hold_cnt <= '0;
    else if (downloading)
      hold_cnt <= HOLD_W'(RESET_HOLD);
    else if (hold_cnt != '0)
      hold_cnt <= hold_cnt - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      init_wait <= 1'b1;
      dl_q <= 1'b0;
      loaded <= 1'b0;
      failed <= 1'b0;
      blink <= '0;
    end else begin
      dl_q <= downloading;
      blink <= blink + 1'b1;
      if (downloading)
        init_wait <= 1'b0;
      if (dl_rise) begin
        loaded <= 1'b0;   // Fresh download
        failed <= 1'b0;
      end else if (done) begin
        loaded <= !error;
        failed <= error;
      end
    end
  end

  // Flags word follows the status bits
  always_ff @(posedge clk) begin
    if (dl_rise)
      mapper_flags <= '0;
    else if (done)
      mapper_flags <= flags;
  end

  assign loader_reset = (hold_cnt == '0) && !downloading;   // Idle between downloads
  assign system_reset = init_wait || downloading || (hold_cnt != '0) || failed;

  // Off while loading, blink on failure, steady when good
  assign led = downloading ? 1'b0 : (failed ? blink[BLINK_BITS-1] : 1'b1);

endmodule

//--- hw/rom_loader_top.sv
// Cartridge image download path: iNES parser, slot-aligned write port, load control
// Parameters set here flow down to the three blocks
`timescale 1ns/1ns

module rom_loader_top
  import loader_pkg::*;
#(
  parameter int ADDR_WIDTH = 22,
  parameter int CE_DIV = 4,
  parameter int RESET_HOLD = 255,
  parameter int BLINK_BITS = 24
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [7:0]             byte_data,
  input  logic                   byte_strobe,
  input  logic                   downloading,
  input  logic                   invert_mirroring,
  output logic [ADDR_WIDTH-1:0]  mem_addr,
  output logic [7:0]             mem_data,
  output logic                   mem_write,
  output logic [FLAGS_WIDTH-1:0] mapper_flags,
  output logic                   loaded,
  output logic                   failed,
  output logic                   system_reset,
  output logic                   led
);

  logic [ADDR_WIDTH-1:0]  wr_addr;
  logic [7:0]             wr_data;
  logic                   wr_strobe;
  logic [FLAGS_WIDTH-1:0] flags;
  logic                   done;
  logic                   error;
  logic                   loader_reset;
  logic                   loader_rst;

  assign loader_rst = reset || loader_reset;   // Parser restarts between downloads

  ines_loader #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) ines_loader_i (
    .clk              (clk),
    .reset            (loader_rst),
    .byte_data        (byte_data),
    .byte_strobe      (byte_strobe),
    .invert_mirroring (invert_mirroring),
    .wr_addr          (wr_addr),
    .wr_data          (wr_data),
    .wr_strobe        (wr_strobe),
    .flags            (flags),
    .done             (done),
    .error            (error)
  );

  write_slot_sync #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .CE_DIV    (CE_DIV)
  ) write_slot_sync_i (
    .clk       (clk),
    .reset     (reset),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_strobe (wr_strobe),
    .mem_addr  (mem_addr),
    .mem_data  (mem_data),
    .mem_write (mem_write)
  );

  load_control #(
    .RESET_HOLD(RESET_HOLD),
    .BLINK_BITS(BLINK_BITS)
  ) load_control_i (
    .clk          (clk),
    .reset        (reset),
    .downloading  (downloading),
    .done         (done),
    .error        (error),
    .flags        (flags),
    .loader_reset (loader_reset),
    .mapper_flags (mapper_flags),
    .loaded       (loaded),
    .failed       (failed),
    .system_reset (system_reset),
    .led          (led)
  );

endmodule

//--- verif/rom_loader_assert.sv
// Bound checks on write spacing, write pulse shape and loader phase
// Bound into write_slot_sync and ines_loader by the bind statements below
`timescale 1ns/1ns

module rom_loader_assert
  import loader_pkg::*;
#(
  parameter bit SLOT_SIDE = 1'b1   // Slot checks in write_slot_sync, phase check in ines_loader
) (
  input logic          clk,
  input logic          reset,
  input logic          wr_strobe,
  input logic          pending,
  input logic          slot_last,
  input logic          mem_write,
  input loader_state_t state
);

  if (SLOT_SIDE) begin : g_slot
    // A new write may only land when the old one issues this cycle
    a_single_pending: assert property (@(posedge clk) disable iff (reset)
      wr_strobe |-> (!pending || slot_last))
      else $error("Write strobe arrived while a write was still pending");

    a_write_pulse: assert property (@(posedge clk) disable iff (reset)
      mem_write |=> !mem_write)
      else $error("mem_write high for two cycles in a row");
  end else begin : g_phase
    a_write_phase: assert property (@(posedge clk) disable iff (reset)
      wr_strobe |-> (state == PRG || state == CHR))
      else $error("Write strobe outside the PRG and CHR phases");
  end

endmodule

bind write_slot_sync rom_loader_assert #(.SLOT_SIDE(1'b1)) slot_checks_i (
  .clk       (clk),
  .reset     (reset),
  .wr_strobe (wr_strobe),
  .pending   (pending),
  .slot_last (slot_last),
  .mem_write (mem_write),
  .state     (loader_pkg::PRG)   // No phase here
);

bind ines_loader rom_loader_assert #(.SLOT_SIDE(1'b0)) phase_checks_i (
  .clk       (clk),
  .reset     (reset),
  .wr_strobe (wr_strobe),
  .pending   (1'b0),             // Slot side checked in write_slot_sync
  .slot_last (1'b0),
  .mem_write (1'b0),
  .state     (state)
);

//--- verif/tb_rom_loader.sv
// Builds iNES images, streams them into the ROM download path and checks writes and status
// Top module is tb_rom_loader and compiles with the RTL from flist.f
`timescale 1ns/1ns

module tb_rom_loader
  import loader_pkg::*;
();

  localparam int ADDR_WIDTH = 22;
  localparam int CE_DIV = 4;
  localparam int RESET_HOLD = 255;
  localparam int BLINK_BITS = 16;   // Short blink period for the failure LED
  localparam logic [ADDR_WIDTH-1:0] CHR_BASE = ADDR_WIDTH'(1) << (ADDR_WIDTH - 1);  // Top bit
  // Images streamed: two 1+1 page, three 1+0 page, one 2+0 page
  localparam int TOTAL_BYTES = 2 * (INES_HDR_LEN + (1 << PRG_PAGE_SHIFT) + (1 << CHR_PAGE_SHIFT))
                             + 3 * (INES_HDR_LEN + (1 << PRG_PAGE_SHIFT))
                             + (INES_HDR_LEN + (2 << PRG_PAGE_SHIFT));
  localparam int CYCLE_LIMIT = TOTAL_BYTES * (CE_DIV + 3) + 6 * (RESET_HOLD + 16)
                             + 2 * (1 << BLINK_BITS) + 20000;

  logic                   clk;
  logic                   reset;
  logic [7:0]             byte_data;
  logic                   byte_strobe;
  logic                   downloading;
  logic                   invert_mirroring;
  logic [ADDR_WIDTH-1:0]  mem_addr;
  logic [7:0]             mem_data;
  logic                   mem_write;
  logic [FLAGS_WIDTH-1:0] mapper_flags;
  logic                   loaded;
  logic                   failed;
  logic                   system_reset;
  logic                   led;

  logic [7:0]            img[$];     // Current image, header first
  logic [ADDR_WIDTH+7:0] exp_q[$];   // Expected writes as {addr, data}
  string                 test_name;
  int                    cycles = 0;

  rom_loader_top #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .CE_DIV    (CE_DIV),
    .RESET_HOLD(RESET_HOLD),
    .BLINK_BITS(BLINK_BITS)
  ) rom_loader_top_i (
    .clk              (clk),
    .reset            (reset),
    .byte_data        (byte_data),
    .byte_strobe      (byte_strobe),
    .downloading      (downloading),
    .invert_mirroring (invert_mirroring),
    .mem_addr         (mem_addr),
    .mem_data         (mem_data),
    .mem_write        (mem_write),
    .mapper_flags     (mapper_flags),
    .loaded           (loaded),
    .failed           (failed),
    .system_reset     (system_reset),
    .led              (led)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
      fail_run($sformatf("Fail %s %s: expected 0x%0h actual 0x%0h",
                         test_name, what, expected, actual));
  endtask

  // Smallest code with 2**code >= pages, capped at 7
  function automatic logic [2:0] log2_code(input int pages);
    int code;
    code = 0;
    while (code < 7 && (1 << code) < pages)
      code++;
    return 3'(code);
  endfunction

  // Expected {ok, flags} from the header bytes in img
  function automatic logic [FLAGS_WIDTH:0] expected_result(input logic inv);
    logic [FLAGS_WIDTH-1:0] f;
    logic                   ok;
    logic                   nes2;
    logic                   junk;
    f = '0;
    junk = 1'b0;
    ok = (img[0] == INES_MAGIC0) && (img[1] == INES_MAGIC1) &&
         (img[2] == INES_MAGIC2) && (img[3] == INES_MAGIC3) && !img[6][2];   // No trainer
    nes2 = (img[7][3:2] == 2'b10);
    for (int i = 8; i < INES_HDR_LEN; i++)
      junk = junk || (img[i] != 8'h00);
    f[FLAG_MAPPER_LO +: 4] = img[6][7:4];
    f[FLAG_MAPPER_LO + 4 +: 4] = (!nes2 && junk) ? 4'h0 : img[7][7:4];   // Dirty header
    f[FLAG_PRG_SIZE +: 3] = log2_code(int'(img[4]));
    f[FLAG_CHR_SIZE +: 3] = log2_code(int'(img[5]));
    f[FLAG_MIRROR] = img[6][0] ^ inv;
    f[FLAG_CHR_RAM] = (img[5] == 8'h00);
    f[FLAG_FOUR_SCREEN] = img[6][3];
    return {ok, f};
  endfunction

  task automatic build_image(input int prg, input int chr, input logic [7:0] f6,
                             input logic [7:0] f7, input logic [7:0] junk, input bit bad_sig);
    int n;
    n = (prg << PRG_PAGE_SHIFT) + (chr << CHR_PAGE_SHIFT);
    img.delete();
    img.push_back(INES_MAGIC0);
    img.push_back(INES_MAGIC1);
    img.push_back(INES_MAGIC2);
    img.push_back(bad_sig ? 8'h00 : INES_MAGIC3);
    img.push_back(8'(prg));
    img.push_back(8'(chr));
    img.push_back(f6);
    img.push_back(f7);
    for (int i = 8; i < INES_HDR_LEN; i++)
      img.push_back((i == 12) ? junk : 8'h00);   // One junk byte in the padding
    for (int i = 0; i < n; i++)
      img.push_back(8'($urandom));   // Random payload
  endtask

  // PRG bytes from zero, CHR bytes from the base
  task automatic queue_writes();
    int                    prg_bytes;
    int                    off;
    logic [ADDR_WIDTH-1:0] a;
    prg_bytes = int'(img[4]) << PRG_PAGE_SHIFT;
    for (int i = INES_HDR_LEN; i < img.size(); i++) begin
      off = i - INES_HDR_LEN;
      a = (off < prg_bytes) ? ADDR_WIDTH'(off) : CHR_BASE + ADDR_WIDTH'(off - prg_bytes);
      exp_q.push_back({a, img[i]});
    end
  endtask

  task automatic stream_image();
    int gap;
    foreach (img[i]) begin
      gap = $urandom_range(3, 0);   // Extra idle cycles
      byte_data = img[i];
      byte_strobe = 1'b1;
      @(negedge clk);
      byte_strobe = 1'b0;
      repeat (CE_DIV - 1 + gap) @(negedge clk);
    end
  endtask

  task automatic run_load(input string name, input int prg, input int chr,
                          input logic [7:0] f6, input logic [7:0] f7, input logic [7:0] junk,
                          input bit bad_sig, input logic inv);
    logic [FLAGS_WIDTH:0] res;
    test_name = name;
    invert_mirroring = inv;
    build_image(prg, chr, f6, f7, junk, bad_sig);
    res = expected_result(inv);
    if (res[FLAGS_WIDTH])
      queue_writes();
    downloading = 1'b1;
    repeat (2) @(negedge clk);
    check_equal("status cleared", 0, {loaded, failed});
    stream_image();
    while (!(loaded || failed))
      @(negedge clk);   // Wait for the load to finish
    downloading = 1'b0;
    repeat (RESET_HOLD + 2) @(negedge clk);   // Hold period drains
    if (exp_q.size() != 0)
      fail_run($sformatf("%s: %0d memory writes never arrived", name, exp_q.size()));
    check_equal("loaded", res[FLAGS_WIDTH], loaded);
    check_equal("failed", !res[FLAGS_WIDTH], failed);
    check_equal("system_reset", !res[FLAGS_WIDTH], system_reset);
    if (res[FLAGS_WIDTH]) begin
      check_equal("mapper_flags", res[FLAGS_WIDTH-1:0], mapper_flags);
      check_equal("led", 1, led);
    end
  endtask

  task automatic wait_led_toggle();
    logic start;
    int   n;
    start = led;
    n = 0;
    while (led == start && n < (1 << BLINK_BITS)) begin
      @(negedge clk);
      n++;
    end
    if (led == start)
      fail_run($sformatf("%s: status LED did not blink after a failed load", test_name));
  endtask

  // Write checker, in order against the expected queue
  always @(posedge clk) begin
    if (mem_write) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("%s: unexpected memory write to 0x%0h", test_name, mem_addr));
      end else begin
        check_equal("mem_addr", exp_q[0][ADDR_WIDTH+7:8], mem_addr);
        check_equal("mem_data", exp_q[0][7:0], mem_data);
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
      fail_run($sformatf("Timeout after %0d cycles in test %s", cycles, test_name));
  end

  initial begin
    void'($urandom(72169));
    reset = 1'b1;
    byte_data = 8'h00;
    byte_strobe = 1'b0;
    downloading = 1'b0;
    invert_mirroring = 1'b0;
    test_name = "after_reset";
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);
    check_equal("system_reset", 1, system_reset);   // Held until first download
    check_equal("loaded", 0, loaded);
    check_equal("failed", 0, failed);
    check_equal("mem_write", 0, mem_write);

    run_load("valid_load", 1, 1, 8'h01, 8'h00, 8'h00, 0, 1'b0);

    run_load("chr_ram_dirty", 1, 0, 8'h31, 8'h40, 8'h5A, 0, 1'b1);
    check_equal("chr_ram flag", 1, mapper_flags[FLAG_CHR_RAM]);
    check_equal("mirror flag", 0, mapper_flags[FLAG_MIRROR]);   // Inverted
    check_equal("mapper", 8'h03, mapper_flags[FLAG_MAPPER_LO +: 8]);

    run_load("nes20_four_screen", 2, 0, 8'h28, 8'h18, 8'h07, 0, 1'b0);
    check_equal("mapper", 8'h12, mapper_flags[FLAG_MAPPER_LO +: 8]);
    check_equal("four_screen flag", 1, mapper_flags[FLAG_FOUR_SCREEN]);
    check_equal("prg size code", 1, mapper_flags[FLAG_PRG_SIZE +: 3]);

    run_load("bad_signature", 1, 0, 8'h00, 8'h00, 8'h00, 1, 1'b0);
    wait_led_toggle();
    run_load("trainer_set", 1, 0, 8'h04, 8'h00, 8'h00, 0, 1'b0);
    wait_led_toggle();

    run_load("reload_after_fail", 1, 1, 8'h10, 8'h00, 8'h00, 0, 1'b0);
    $display("All checks passed");
    $finish;
  end

endmodule

//--- flist.f
hw/loader_pkg.sv
hw/ines_loader.sv
hw/write_slot_sync.sv
hw/load_control.sv
hw/rom_loader_top.sv
verif/rom_loader_assert.sv
verif/tb_rom_loader.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from its output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rom_loader -f flist.f

# Keep going on a non-zero simulator exit so the output is still searched
out=$(./obj_dir/Vtb_rom_loader 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
